/* verilog/hdc_pkg.sv */
package hdc_pkg;

    // core array size
    localparam int NUM_CORES = 8;
    localparam int CORE_W    = 3;

    // hypervector and item memory geometry
    localparam int WORD_W     = 32;
    localparam int ITEM_DEPTH = 128;
    localparam int ADDR_W     = 7;

    // rotate amount taken from the low bits of an item word
    localparam int ROT_W = $clog2(WORD_W);

    // base hypervector that every symbol rotates
    localparam logic [WORD_W-1:0] BASE_VECTOR = 32'd33215360;

    // cycles to wait for symbols still in the core pipelines
    localparam int DRAIN_CYCLES = 4;
    localparam int DRAIN_W      = $clog2(DRAIN_CYCLES);

    // sequencer states
    typedef enum logic [1:0] {
        IDLE,
        DRAIN,
        SNAP,
        SHIFT
    } seq_state_t;

endpackage

/* verilog/hdc_ctrl_if.sv */
`timescale 1ns/10ps

interface hdc_ctrl_if
    import hdc_pkg::*;
();

    // one-cycle accumulator clear
    logic                 init;
    // per-core symbol strobe that is one-hot or zero
    logic [NUM_CORES-1:0] exec;
    logic [ADDR_W-1:0]    sym;
    // copy accumulators into snapshots
    logic                 snap;
    // move snapshots one core toward core 0
    logic                 shift;

    modport seq (
        output init,
        output exec,
        output sym,
        output snap,
        output shift
    );

    modport core (
        input init,
        input exec,
        input sym,
        input snap,
        input shift
    );

endinterface

/* verilog/hdc_sequencer.sv */
`timescale 1ns/10ps

module hdc_sequencer
    import hdc_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              init_req,
    input  logic              sym_valid,
    input  logic [CORE_W-1:0] sym_core,
    input  logic [ADDR_W-1:0] sym,
    input  logic              finish,
    hdc_ctrl_if.seq           ctrl,
    output logic              busy
);

    seq_state_t         state;
    logic [DRAIN_W-1:0] drain_cnt;
    logic [CORE_W-1:0]  shift_cnt;
    logic               tail;
    logic               accept;

    // tail covers the cycle of the last readout word
    assign busy   = (state != IDLE) || tail;
    assign accept = !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            drain_cnt <= '0;
            shift_cnt <= '0;
            tail      <= 1'b0;
        end else begin
            tail <= 1'b0;
            case (state)
                IDLE: begin
                    if (finish && accept) begin
                        state     <= DRAIN;
                        drain_cnt <= '0;
                    end
                end
                DRAIN: begin
                    // let the last symbols reach the accumulators
                    if (drain_cnt == DRAIN_W'(DRAIN_CYCLES - 1)) begin
                        state <= SNAP;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                SNAP: begin
                    state     <= SHIFT;
                    shift_cnt <= '0;
                end
                SHIFT: begin
                    if (shift_cnt == CORE_W'(NUM_CORES - 1)) begin
                        state <= IDLE;
                        tail  <= 1'b1;
                    end else begin
                        shift_cnt <= shift_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // symbol strobe and clear one cycle after the request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl.exec <= '0;
            ctrl.init <= 1'b0;
        end else begin
            ctrl.exec <= (sym_valid && accept) ? (NUM_CORES'(1) << sym_core) : '0;
            ctrl.init <= init_req && accept;
        end
    end

    // symbol payload travels with exec
    always_ff @(posedge clk) begin
        if (sym_valid && accept) begin
            ctrl.sym <= sym;
        end
    end

    assign ctrl.snap  = (state == SNAP);
    assign ctrl.shift = (state == SHIFT);

endmodule

/* verilog/hdc_core.sv */
`timescale 1ns/10ps

module hdc_core
    import hdc_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mem_we,
    input  logic [ADDR_W-1:0] mem_addr,
    input  logic [WORD_W-1:0] mem_data,
    input  logic              exec_en,
    hdc_ctrl_if.core          ctrl,
    input  logic [WORD_W-1:0] snap_in,
    output logic [WORD_W-1:0] snap_out
);

    logic [WORD_W-1:0]   item_mem [ITEM_DEPTH];
    logic [2:0]          exec_d;
    logic [2:0]          init_d;
    logic [ADDR_W-1:0]   addr_q;
    logic [WORD_W-1:0]   item_q;
    logic [ROT_W-1:0]    rot_q;
    logic [2*WORD_W-1:0] base_dbl;
    logic [WORD_W-1:0]   rot_vec;
    logic [WORD_W-1:0]   acc;
    logic [WORD_W-1:0]   snap_q;

    // broadcast item memory holds the same words in every core
    always_ff @(posedge clk) begin
        if (mem_we) begin
            item_mem[mem_addr] <= mem_data;
        end
    end

    // strobes follow the data through three stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exec_d <= '0;
            init_d <= '0;
        end else begin
            exec_d <= {exec_d[1:0], exec_en};
            init_d <= {init_d[1:0], ctrl.init};
        end
    end

    // symbol, item lookup, rotate amount
    always_ff @(posedge clk) begin
        addr_q <= ctrl.sym;
        item_q <= item_mem[addr_q];
        rot_q  <= item_q[ROT_W-1:0];
    end

    // right rotate via a doubled vector
    assign base_dbl = {BASE_VECTOR, BASE_VECTOR} >> rot_q;
    assign rot_vec  = base_dbl[WORD_W-1:0];

    // clear wins over a same-edge update
    always_ff @(posedge clk) begin
        if (init_d[2]) begin
            acc <= '0;
        end else if (exec_d[2]) begin
            acc <= acc ^ rot_vec;
        end
    end

    // snapshot stage of the readout chain
    always_ff @(posedge clk) begin
        if (ctrl.snap) begin
            snap_q <= acc;
        end else if (ctrl.shift) begin
            snap_q <= snap_in;
        end
    end

    assign snap_out = snap_q;

endmodule

/* verilog/hdc_readout.sv */
`timescale 1ns/10ps

module hdc_readout
    import hdc_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              snap,
    input  logic              shift,
    input  logic [WORD_W-1:0] chain_head,
    output logic              result_valid,
    output logic [CORE_W-1:0] result_idx,
    output logic [WORD_W-1:0] result_data,
    output logic              done
);

    logic [CORE_W-1:0] word_cnt;

    // core 0 leaves the chain first as word 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt     <= '0;
            result_valid <= 1'b0;
            result_idx   <= '0;
            done         <= 1'b0;
        end else begin
            if (snap) begin
                word_cnt <= '0;
            end else if (shift) begin
                word_cnt <= word_cnt + 1'b1;
            end
            result_valid <= shift;
            if (shift) begin
                result_idx <= word_cnt;
            end
            // one cycle after the eighth word
            done <= result_valid && (result_idx == CORE_W'(NUM_CORES - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (shift) begin
            result_data <= chain_head;
        end
    end

endmodule

/* verilog/hdc_encoder_top.sv */
`timescale 1ns/10ps

module hdc_encoder_top
    import hdc_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mem_we,
    input  logic [ADDR_W-1:0] mem_addr,
    input  logic [WORD_W-1:0] mem_data,
    input  logic              init,
    input  logic              sym_valid,
    input  logic [CORE_W-1:0] sym_core,
    input  logic [ADDR_W-1:0] sym,
    input  logic              finish,
    output logic              busy,
    output logic              result_valid,
    output logic [CORE_W-1:0] result_idx,
    output logic [WORD_W-1:0] result_data,
    output logic              done
);

    // chain[i] is the snapshot leaving core i
    logic [WORD_W-1:0] chain [NUM_CORES+1];

    hdc_ctrl_if ctrl ();

    hdc_sequencer i_hdc_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .init_req  (init),
        .sym_valid (sym_valid),
        .sym_core  (sym_core),
        .sym       (sym),
        .finish    (finish),
        .ctrl      (ctrl),
        .busy      (busy)
    );

    // last core shifts in zeros
    assign chain[NUM_CORES] = '0;

    for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
        hdc_core i_hdc_core (
            .clk      (clk),
            .rst_n    (rst_n),
            .mem_we   (mem_we),
            .mem_addr (mem_addr),
            .mem_data (mem_data),
            .exec_en  (ctrl.exec[i]),
            .ctrl     (ctrl),
            .snap_in  (chain[i+1]),
            .snap_out (chain[i])
        );
    end

    hdc_readout i_hdc_readout (
        .clk          (clk),
        .rst_n        (rst_n),
        .snap         (ctrl.snap),
        .shift        (ctrl.shift),
        .chain_head   (chain[0]),
        .result_valid (result_valid),
        .result_idx   (result_idx),
        .result_data  (result_data),
        .done         (done)
    );

endmodule

/* sim/tb_hdc_encoder.sv */
`timescale 1ns/10ps

module tb_hdc_encoder
    import hdc_pkg::*;
();

    localparam logic [31:0] SEED = 32'd9997;
    localparam int RESET_CYCLES = 16;
    // rough length of each test in cycles
    localparam int LEN_IDLE    = 20;
    localparam int LEN_LOAD    = ITEM_DEPTH + 4;
    localparam int LEN_READOUT = 24;
    localparam int LEN_SINGLE  = 12 + LEN_READOUT;
    localparam int LEN_STREAM  = 68 + LEN_READOUT;
    localparam int LEN_CLEAR   = 16 + LEN_READOUT;
    localparam int LEN_BUSY    = 3 * LEN_READOUT;
    localparam int LEN_REWRITE = LEN_LOAD + 36 + LEN_READOUT;
    localparam int TIMEOUT_CYCLES = 2 * (LEN_IDLE + LEN_LOAD + LEN_SINGLE + LEN_STREAM
                                    + LEN_CLEAR + LEN_BUSY + LEN_REWRITE) + RESET_CYCLES;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              mem_we;
    logic [ADDR_W-1:0] mem_addr;
    logic [WORD_W-1:0] mem_data;
    logic              init;
    logic              sym_valid;
    logic [CORE_W-1:0] sym_core;
    logic [ADDR_W-1:0] sym;
    logic              finish;
    logic              busy;
    logic              result_valid;
    logic [CORE_W-1:0] result_idx;
    logic [WORD_W-1:0] result_data;
    logic              done;

    // reference model
    logic [WORD_W-1:0] item_model [ITEM_DEPTH];
    logic [WORD_W-1:0] exp_acc [NUM_CORES];
    logic [31:0]       rng_state = SEED;
    logic              seen_finish = 1'b0;
    string             test_name = "reset";
    int                value_errors = 0;
    int                protocol_errors = 0;
    int                valid_cnt = 0;
    int                cycle_cnt = 0;

    hdc_encoder_top i_hdc_encoder_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data),
        .init         (init),
        .sym_valid    (sym_valid),
        .sym_core     (sym_core),
        .sym          (sym),
        .finish       (finish),
        .busy         (busy),
        .result_valid (result_valid),
        .result_idx   (result_idx),
        .result_data  (result_data),
        .done         (done)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout in %s: no done after %0d cycles", test_name, cycle_cnt);
            $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
            $display("** FAIL **");
            $finish;
        end
    end

    // result_valid cycles since the last done
    always @(posedge clk) begin
        if (!rst_n || done) begin
            valid_cnt <= 0;
        end else if (result_valid) begin
            valid_cnt <= valid_cnt + 1;
        end
    end

    a_result_value: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> result_data == exp_acc[result_idx])
    else begin
        value_errors++;
        $display("[FAIL] %s: word %0d expected %h, actual %h", test_name,
                 $sampled(result_idx), exp_acc[$sampled(result_idx)], $sampled(result_data));
    end

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_finish |-> !busy && !result_valid && !done)
    else begin
        protocol_errors++;
        $display("protocol error in %s: outputs active before the first finish", test_name);
    end

    a_busy_rises: assert property (@(posedge clk) disable iff (!rst_n)
        finish && !busy |=> busy)
    else begin
        protocol_errors++;
        $display("protocol error in %s: busy did not rise after finish", test_name);
    end

    a_valid_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> busy)
    else begin
        protocol_errors++;
        $display("protocol error in %s: result word shown while not busy", test_name);
    end

    a_idx_steps: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && result_idx != 3'd7 |=>
            result_valid && result_idx == $past(result_idx) + 3'd1)
    else begin
        protocol_errors++;
        $display("protocol error in %s: result words not contiguous 0 to 7", test_name);
    end

    a_done_after_eight: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $past(result_valid) && $past(result_idx) == 3'd7 && !busy
                 && valid_cnt == NUM_CORES)
    else begin
        protocol_errors++;
        $display("protocol error in %s: done without eight words or busy still high",
                 test_name);
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // one bit position per step
    function automatic logic [WORD_W-1:0] rotate_right(input logic [WORD_W-1:0] v,
                                                        input int amt);
        logic [WORD_W-1:0] r;
        r = v;
        for (int k = 0; k < amt; k++) begin
            r = {r[0], r[WORD_W-1:1]};
        end
        return r;
    endfunction

    task automatic write_mem(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
        @(negedge clk);
        {mem_we, init, sym_valid, finish} = 4'b1000;
        mem_addr = addr;
        mem_data = data;
        item_model[addr] = data;
    endtask

    task automatic load_random_memory();
        for (int a = 0; a < ITEM_DEPTH; a++) begin
            rng_state = xorshift32(rng_state);
            write_mem(ADDR_W'(a), rng_state);
        end
    endtask

    task automatic send_init();
        @(negedge clk);
        {mem_we, init, sym_valid, finish} = 4'b0100;
        if (!busy) begin
            for (int c = 0; c < NUM_CORES; c++) begin
                exp_acc[c] = '0;
            end
        end
    endtask

    task automatic send_sym(input logic [CORE_W-1:0] core, input logic [ADDR_W-1:0] s);
        @(negedge clk);
        {mem_we, init, sym_valid, finish} = 4'b0010;
        sym_core = core;
        sym = s;
        if (!busy) begin
            exp_acc[core] = exp_acc[core] ^ rotate_right(BASE_VECTOR, item_model[s][4:0]);
        end
    endtask

    task automatic send_random_syms(input int count);
        for (int n = 0; n < count; n++) begin
            rng_state = xorshift32(rng_state);
            send_sym(rng_state[2:0], rng_state[14:8]);
        end
    endtask

    task automatic idle_inputs();
        @(negedge clk);
        {mem_we, init, sym_valid, finish} = 4'b0000;
    endtask

    task automatic start_finish();
        @(negedge clk);
        {mem_we, init, sym_valid, finish} = 4'b0001;
        seen_finish = 1'b1;
        @(negedge clk);
        finish = 1'b0;
    endtask

    task automatic wait_done();
        while (!done) begin
            @(negedge clk);
        end
    endtask

    initial begin
        {rst_n, mem_we, init, sym_valid, finish} = 5'b00000;
        mem_addr = '0;
        mem_data = '0;
        sym_core = '0;
        sym = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_name = "idle_after_reset";
        repeat (LEN_IDLE) @(negedge clk);
        load_random_memory();

        test_name = "one_symbol_per_core";
        send_init();
        for (int c = 0; c < NUM_CORES; c++) begin
            rng_state = xorshift32(rng_state);
            send_sym(CORE_W'(c), rng_state[6:0]);
        end
        idle_inputs();
        start_finish();
        wait_done();

        // keeps accumulating on top of the previous test
        test_name = "random_stream";
        send_random_syms(64);
        idle_inputs();
        start_finish();
        wait_done();

        test_name = "init_clears";
        send_init();
        for (int n = 0; n < 12; n++) begin
            rng_state = xorshift32(rng_state);
            send_sym((n % 3 == 0) ? 3'd1 : (n % 3 == 1) ? 3'd2 : 3'd5, rng_state[6:0]);
        end
        idle_inputs();
        start_finish();
        wait_done();

        test_name = "ignored_while_busy";
        start_finish();
        while (busy) begin
            rng_state = xorshift32(rng_state);
            {mem_we, init, sym_valid, finish} = {1'b0, rng_state[0], 1'b1, 1'b0};
            sym_core = rng_state[3:1];
            sym = rng_state[10:4];
            @(negedge clk);
        end
        {init, sym_valid} = 2'b00;
        wait_done();
        start_finish();
        wait_done();

        test_name = "memory_rewrite";
        load_random_memory();
        send_init();
        send_random_syms(32);
        idle_inputs();
        start_finish();
        wait_done();

        repeat (4) @(negedge clk);
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* Bender.yml */
package:
  name: hdc_encoder

sources:
  - verilog/hdc_pkg.sv
  - verilog/hdc_ctrl_if.sv
  - verilog/hdc_sequencer.sv
  - verilog/hdc_core.sv
  - verilog/hdc_readout.sv
  - verilog/hdc_encoder_top.sv
  - target: simulation
    files:
      - sim/tb_hdc_encoder.sv

/* compile.f */
verilog/hdc_pkg.sv
verilog/hdc_ctrl_if.sv
verilog/hdc_sequencer.sv
verilog/hdc_core.sv
verilog/hdc_readout.sv
verilog/hdc_encoder_top.sv
sim/tb_hdc_encoder.sv
